// File: hw/tetris_grid_pkg.sv
package tetris_grid_pkg;

  //////////////////////////////////////////////////////////////////////
  // board geometry
  //////////////////////////////////////////////////////////////////////

  localparam int GRID_ROWS = 22;
  localparam int GRID_COLS = 10;

  // 0 is an empty cell
  typedef logic [2:0] cell_t;

  // colour of a locked cell is the ordinal plus one
  typedef enum logic [2:0] {
    PK_O,
    PK_I,
    PK_T,
    PK_S,
    PK_Z,
    PK_J,
    PK_L
  } piece_kind_t;

  // top left corner of the 4x4 box
  typedef struct packed {
    piece_kind_t       kind;
    logic [1:0]        rot;
    logic [4:0]        row;
    logic signed [4:0] col;  // may go below 0 at the left wall
  } piece_pos_t;

  typedef cell_t [GRID_COLS-1:0] row_t;

  localparam logic [4:0]        SPAWN_ROW = 5'd0;
  localparam logic signed [4:0] SPAWN_COL = 5'sd3;

endpackage

// File: hw/tetris_game_pkg.sv
package tetris_game_pkg;
  import tetris_grid_pkg::*;

  localparam int WB_ADR_W = 6;
  localparam int WB_DAT_W = 32;

  //////////////////////////////////////////////////////////////////////
  // register map, word addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [WB_ADR_W-1:0] REG_CTRL     = 6'd0;   // write, command op
  localparam logic [WB_ADR_W-1:0] REG_STATUS   = 6'd1;
  localparam logic [WB_ADR_W-1:0] REG_LINES    = 6'd2;
  localparam logic [WB_ADR_W-1:0] REG_PRESET   = 6'd3;   // bit 3 enable, 2..0 kind
  localparam logic [WB_ADR_W-1:0] REG_ROW_BASE = 6'd32;  // row r at 32 + r

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PLAY,
    ST_MOVE,
    ST_LOCK,
    ST_CLEAR,
    ST_SPAWN,
    ST_OVER
  } game_state_t;

  typedef enum logic [2:0] {
    OP_START,
    OP_LEFT,
    OP_RIGHT,
    OP_ROT_CW,
    OP_ROT_CCW,
    OP_DROP
  } cmd_op_t;

  typedef struct packed {
    logic    valid;
    cmd_op_t op;
  } host_cmd_t;

  typedef struct packed {
    game_state_t state;
    logic        busy;
    logic        game_over;
    piece_pos_t  pos;  // active piece, not part of the readback rows
  } status_t;

endpackage

// File: hw/piece_gen.sv
`timescale 1ns/10ps

module piece_gen
  import tetris_grid_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        take_i,
  input  logic        preset_en_i,
  input  piece_kind_t preset_kind_i,
  output piece_kind_t kind_o
);

  piece_kind_t seq_q;
  logic        preset_ok;

  // kind 7 has no shape, fall back to the sequence
  assign preset_ok = preset_en_i && (preset_kind_i <= PK_L);
  assign kind_o    = preset_ok ? preset_kind_i : seq_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      seq_q <= PK_O;
    end else if (take_i) begin
      // sequence keeps moving under a preset too
      if (seq_q == PK_L) begin
        seq_q <= PK_O;
      end else begin
        seq_q <= piece_kind_t'(seq_q + 3'd1);
      end
    end
  end

endmodule

// File: hw/piece_rom.sv
`timescale 1ns/10ps

module piece_rom
  import tetris_grid_pkg::*;
(
  input  piece_kind_t kind_i,
  input  logic [1:0]  rot_i,
  output logic [15:0] mask_o
);

  // msb first: box row 0 cols 0..3, then row 1 and so on
  always_comb begin
    mask_o = '0;
    case (kind_i)
      PK_O: mask_o = 16'b1100_1100_0000_0000;  // same in every rotation
      PK_I: case (rot_i)
        2'd0: mask_o = 16'b0000_1111_0000_0000;
        2'd1: mask_o = 16'b0010_0010_0010_0010;
        2'd2: mask_o = 16'b0000_0000_1111_0000;
        2'd3: mask_o = 16'b0100_0100_0100_0100;
      endcase
      PK_T: case (rot_i)
        2'd0: mask_o = 16'b0100_1110_0000_0000;
        2'd1: mask_o = 16'b0100_0110_0100_0000;
        2'd2: mask_o = 16'b0000_1110_0100_0000;
        2'd3: mask_o = 16'b0100_1100_0100_0000;
      endcase
      PK_S: case (rot_i)
        2'd0: mask_o = 16'b0110_1100_0000_0000;
        2'd1: mask_o = 16'b0100_0110_0010_0000;
        2'd2: mask_o = 16'b0000_0110_1100_0000;
        2'd3: mask_o = 16'b1000_1100_0100_0000;
      endcase
      PK_Z: case (rot_i)
        2'd0: mask_o = 16'b1100_0110_0000_0000;
        2'd1: mask_o = 16'b0010_0110_0100_0000;
        2'd2: mask_o = 16'b0000_1100_0110_0000;
        2'd3: mask_o = 16'b0100_1100_1000_0000;
      endcase
      PK_J: case (rot_i)
        2'd0: mask_o = 16'b1000_1110_0000_0000;
        2'd1: mask_o = 16'b0110_0100_0100_0000;
        2'd2: mask_o = 16'b0000_1110_0010_0000;
        2'd3: mask_o = 16'b0100_0100_1100_0000;
      endcase
      PK_L: case (rot_i)
        2'd0: mask_o = 16'b0010_1110_0000_0000;
        2'd1: mask_o = 16'b0100_0100_0110_0000;
        2'd2: mask_o = 16'b0000_1110_1000_0000;
        2'd3: mask_o = 16'b1100_0100_0100_0000;
      endcase
      default: mask_o = '0;  // unused encoding
    endcase
  end

endmodule

// File: hw/fit_check.sv
`timescale 1ns/10ps

module fit_check
  import tetris_grid_pkg::*;
(
  input  piece_pos_t           cand_i,
  input  logic [15:0]          mask_i,
  input  row_t [GRID_ROWS-1:0] grid_i,
  output logic                 fits_o
);

  always_comb begin
    int cr;
    int cc;
    fits_o = 1'b1;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        cr = int'(cand_i.row) + r;
        cc = int'($signed(cand_i.col)) + c;
        if (mask_i[15 - (r*4 + c)]) begin
          if (cr >= GRID_ROWS || cc < 0 || cc >= GRID_COLS) begin
            fits_o = 1'b0;  // off the board
          end else if (grid_i[cr][cc] != '0) begin
            fits_o = 1'b0;  // occupied
          end
        end
      end
    end
  end

endmodule

// File: hw/playfield.sv
`timescale 1ns/10ps

module playfield
  import tetris_grid_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 grid_reset_i,
  input  logic                 lock_i,
  input  piece_pos_t           lock_pos_i,
  input  logic [15:0]          lock_mask_i,
  input  logic                 clear_start_i,
  output row_t [GRID_ROWS-1:0] grid_o,
  output logic                 clear_done_o,
  output logic [2:0]           rows_removed_o
);

  row_t [GRID_ROWS-1:0] grid_q;
  row_t [GRID_ROWS-1:0] locked_grid;
  logic                 scanning_q;
  logic [4:0]           scan_row_q;
  logic [2:0]           removed_q;
  logic                 done_q;
  logic                 row_full;
  logic                 lock_overlap;
  cell_t                lock_colour;

  assign grid_o         = grid_q;
  assign clear_done_o   = done_q;
  assign rows_removed_o = removed_q;
  assign lock_colour    = cell_t'(lock_pos_i.kind) + 3'd1;

  // grid with the piece painted in
  always_comb begin
    int pr;
    int pc;
    locked_grid  = grid_q;
    lock_overlap = 1'b0;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        pr = int'(lock_pos_i.row) + r;
        pc = int'($signed(lock_pos_i.col)) + c;
        if (lock_mask_i[15 - (r*4 + c)] && pr < GRID_ROWS && pc >= 0 && pc < GRID_COLS) begin
          if (grid_q[pr][pc] != '0) begin
            lock_overlap = 1'b1;
          end
          locked_grid[pr][pc] = lock_colour;
        end
      end
    end
  end

  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < GRID_COLS; c++) begin
      if (grid_q[scan_row_q][c] == '0) begin
        row_full = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bottom-up scan, a full row pulls everything above down by one
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grid_q     <= '0;
      scanning_q <= 1'b0;
      scan_row_q <= '0;
      removed_q  <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (grid_reset_i) begin
        grid_q     <= '0;
        scanning_q <= 1'b0;
      end else if (lock_i) begin
        grid_q <= locked_grid;
      end else if (scanning_q) begin
        if (row_full) begin
          for (int i = 1; i < GRID_ROWS; i++) begin
            if (i <= scan_row_q) begin
              grid_q[i] <= grid_q[i-1];
            end
          end
          grid_q[0] <= '0;
          removed_q <= removed_q + 3'd1;  // same row scanned again
        end else if (scan_row_q == 5'd0) begin
          scanning_q <= 1'b0;
          done_q     <= 1'b1;
        end else begin
          scan_row_q <= scan_row_q - 5'd1;
        end
      end
      if (clear_start_i) begin
        scanning_q <= 1'b1;
        scan_row_q <= 5'(GRID_ROWS - 1);
        removed_q  <= '0;
      end
    end
  end

  // the controller only locks positions that passed the fit check
  a_no_overwrite : assert property (@(posedge clk) disable iff (rst) lock_i |-> !lock_overlap)
    else $error("lock overwrote a filled cell");

endmodule

// File: hw/tetris_ctrl.sv
`timescale 1ns/10ps

module tetris_ctrl
  import tetris_grid_pkg::*;
  import tetris_game_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  host_cmd_t   cmd_i,
  input  logic        fits_i,
  input  piece_kind_t next_kind_i,
  input  logic        clear_done_i,
  input  logic [2:0]  rows_removed_i,
  output logic        cmd_ready_o,
  output piece_pos_t  cand_o,
  output logic        take_o,
  output logic        lock_o,
  output logic        clear_start_o,
  output logic        grid_reset_o,
  output status_t     status_o,
  output logic [15:0] lines_o,
  output logic        game_over_o
);

  game_state_t state_q;
  game_state_t state_d;
  piece_pos_t  pos_q;
  cmd_op_t     op_q;
  logic [15:0] lines_q;
  logic        busy;
  logic        accept;

  assign busy        = !(state_q inside {ST_IDLE, ST_PLAY, ST_OVER});
  assign cmd_ready_o = !busy;
  assign accept      = cmd_i.valid && cmd_ready_o;
  assign lock_o      = (state_q == ST_LOCK);
  assign clear_start_o = (state_q == ST_LOCK);  // scan starts on the locked grid
  assign game_over_o = (state_q == ST_OVER);
  assign lines_o     = lines_q;
  assign status_o    = '{state: state_q, busy: busy, game_over: game_over_o, pos: pos_q};

  //////////////////////////////////////////////////////////////////////
  // candidate position
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cand_o = pos_q;  // lock uses the active piece as is
    case (state_q)
      ST_MOVE: begin
        case (op_q)
          OP_LEFT:    cand_o.col = pos_q.col - 5'sd1;
          OP_RIGHT:   cand_o.col = pos_q.col + 5'sd1;
          OP_ROT_CW:  cand_o.rot = pos_q.rot + 2'd1;  // wraps mod 4
          OP_ROT_CCW: cand_o.rot = pos_q.rot - 2'd1;
          OP_DROP:    cand_o.row = pos_q.row + 5'd1;
          default:    cand_o = pos_q;
        endcase
      end
      ST_SPAWN: begin
        cand_o = '{kind: next_kind_i, rot: 2'd0, row: SPAWN_ROW, col: SPAWN_COL};
      end
      default: cand_o = pos_q;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // game FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    grid_reset_o = 1'b0;
    take_o       = 1'b0;
    case (state_q)
      ST_IDLE, ST_OVER: begin
        if (accept && cmd_i.op == OP_START) begin
          grid_reset_o = 1'b1;
          state_d      = ST_SPAWN;
        end
      end
      ST_PLAY: begin
        // start and unknown ops are taken and dropped
        if (accept && cmd_i.op inside {OP_LEFT, OP_RIGHT, OP_ROT_CW, OP_ROT_CCW, OP_DROP}) begin
          state_d = ST_MOVE;
        end
      end
      ST_MOVE: begin
        if (!fits_i && op_q == OP_DROP) begin
          state_d = ST_LOCK;  // landed
        end else begin
          state_d = ST_PLAY;
        end
      end
      ST_LOCK: state_d = ST_CLEAR;
      ST_CLEAR: begin
        if (clear_done_i) begin
          state_d = ST_SPAWN;
        end
      end
      ST_SPAWN: begin
        take_o  = fits_i;
        state_d = fits_i ? ST_PLAY : ST_OVER;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ST_IDLE;
      pos_q   <= '0;
      lines_q <= '0;
    end else begin
      state_q <= state_d;
      if (grid_reset_o) begin
        lines_q <= '0;
      end else if (state_q == ST_CLEAR && clear_done_i) begin
        lines_q <= lines_q + 16'(rows_removed_i);
      end
      if ((state_q == ST_MOVE || state_q == ST_SPAWN) && fits_i) begin
        pos_q <= cand_o;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_PLAY && accept) begin
      op_q <= cmd_i.op;
    end
  end

  // the piece being written still sits on empty cells inside the board
  a_lock_fits : assert property (@(posedge clk) disable iff (rst) lock_o |-> fits_i)
    else $error("lock of a piece that does not fit the grid");

  // playfield reports done only while the FSM waits for it
  a_clear_wait : assert property (@(posedge clk) disable iff (rst)
    clear_done_i |-> state_q == ST_CLEAR)
    else $error("line clear done seen outside the clear state");

endmodule

// File: hw/tetris_wb_regs.sv
`timescale 1ns/10ps

module tetris_wb_regs
  import tetris_grid_pkg::*;
  import tetris_game_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [WB_ADR_W-1:0]  adr_i,
  input  logic [WB_DAT_W-1:0]  dat_i,
  input  logic                 cmd_ready_i,
  input  status_t              status_i,
  input  logic [15:0]          lines_i,
  input  row_t [GRID_ROWS-1:0] grid_i,
  output logic [WB_DAT_W-1:0]  dat_o,
  output logic                 ack_o,
  output host_cmd_t            cmd_o,
  output logic                 preset_en_o,
  output piece_kind_t          preset_kind_o
);

  logic                req;
  logic                ctrl_wr;
  logic                cmd_done;
  logic [WB_ADR_W-1:0] row_idx;
  logic [WB_DAT_W-1:0] rd_data;
  host_cmd_t           cmd_q;

  assign req      = cyc_i && stb_i && !ack_o;  // one access per strobe
  assign ctrl_wr  = req && we_i && (adr_i == REG_CTRL);
  assign cmd_done = cmd_q.valid && cmd_ready_i;
  assign cmd_o    = cmd_q;
  assign row_idx  = adr_i - REG_ROW_BASE;

  // read mux
  always_comb begin
    rd_data = '0;
    case (adr_i)
      REG_STATUS: rd_data = WB_DAT_W'(status_i);
      REG_LINES:  rd_data = WB_DAT_W'(lines_i);
      REG_PRESET: rd_data = WB_DAT_W'({preset_en_o, preset_kind_o});
      default: begin
        if (adr_i >= REG_ROW_BASE && row_idx < GRID_ROWS) begin
          rd_data = WB_DAT_W'(grid_i[row_idx]);
        end
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_q         <= '0;
      ack_o         <= 1'b0;
      preset_en_o   <= 1'b0;
      preset_kind_o <= PK_O;
    end else begin
      // command writes wait for the controller, the rest finish at once
      ack_o <= cmd_done || (req && !(we_i && adr_i == REG_CTRL));
      if (ctrl_wr && !cmd_q.valid) begin
        cmd_q.valid <= 1'b1;
        cmd_q.op    <= cmd_op_t'(dat_i[2:0]);
      end else if (cmd_done) begin
        cmd_q.valid <= 1'b0;
      end
      if (req && we_i && adr_i == REG_PRESET) begin
        preset_en_o   <= dat_i[3];
        preset_kind_o <= piece_kind_t'(dat_i[2:0]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && !we_i) begin
      dat_o <= rd_data;
    end
  end

  // master holds stb until ack, so ack must drop right after
  a_ack_single : assert property (@(posedge clk) disable iff (rst) ack_o |=> !ack_o)
    else $error("wb ack held for two cycles");

endmodule

// File: hw/tetris_top.sv
`timescale 1ns/10ps

module tetris_top
  import tetris_grid_pkg::*;
  import tetris_game_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [WB_ADR_W-1:0] adr_i,
  input  logic [WB_DAT_W-1:0] dat_i,
  output logic [WB_DAT_W-1:0] dat_o,
  output logic                ack_o,
  output logic                game_over_o
);

  host_cmd_t            cmd;
  logic                 cmd_ready;
  status_t              status;
  logic [15:0]          lines;
  row_t [GRID_ROWS-1:0] grid;
  logic                 preset_en;
  piece_kind_t          preset_kind;
  piece_kind_t          next_kind;
  logic                 take;
  piece_pos_t           cand;
  logic [15:0]          mask;
  logic                 fits;
  logic                 lock;
  logic                 clear_start;
  logic                 clear_done;
  logic [2:0]           rows_removed;
  logic                 grid_reset;

  tetris_wb_regs u_regs (
    .clk(clk), .rst(rst),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .dat_i(dat_i),
    .cmd_ready_i(cmd_ready), .status_i(status), .lines_i(lines), .grid_i(grid),
    .dat_o(dat_o), .ack_o(ack_o), .cmd_o(cmd),
    .preset_en_o(preset_en), .preset_kind_o(preset_kind)
  );

  tetris_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .cmd_i(cmd), .fits_i(fits), .next_kind_i(next_kind),
    .clear_done_i(clear_done), .rows_removed_i(rows_removed),
    .cmd_ready_o(cmd_ready), .cand_o(cand), .take_o(take), .lock_o(lock),
    .clear_start_o(clear_start), .grid_reset_o(grid_reset),
    .status_o(status), .lines_o(lines), .game_over_o(game_over_o)
  );

  piece_gen u_gen (
    .clk(clk), .rst(rst), .take_i(take),
    .preset_en_i(preset_en), .preset_kind_i(preset_kind), .kind_o(next_kind)
  );

  // one shape lookup serves both fit check and lock
  piece_rom u_rom (.kind_i(cand.kind), .rot_i(cand.rot), .mask_o(mask));

  fit_check u_fit (.cand_i(cand), .mask_i(mask), .grid_i(grid), .fits_o(fits));

  playfield u_field (
    .clk(clk), .rst(rst),
    .grid_reset_i(grid_reset), .lock_i(lock), .lock_pos_i(cand), .lock_mask_i(mask),
    .clear_start_i(clear_start),
    .grid_o(grid), .clear_done_o(clear_done), .rows_removed_o(rows_removed)
  );

endmodule

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// first problem ends the run
task automatic fail_run(string why);
  $display("%s", why);
  $display("Checks failed");
  $fatal(1, "run stopped");
endtask

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_status(int step, status_t got, status_t exp);
  if (got !== exp) begin
    fail_run($sformatf("Error at %0t: step %0d status %h, expected %h",
                       $time, step, got, exp));
  end
endtask

task automatic check_row(int step, int r, row_t got, row_t exp);
  if (got !== exp) begin
    fail_run($sformatf("Error at %0t: step %0d row %0d is %h, expected %h",
                       $time, step, r, got, exp));
  end
endtask

task automatic check_count(int step, logic [15:0] got, logic [15:0] exp);
  if (got !== exp) begin
    fail_run($sformatf("Error at %0t: step %0d line count %0d, expected %0d",
                       $time, step, got, exp));
  end
endtask

task automatic check_flag(int step, logic got, logic exp);
  if (got !== exp) begin
    fail_run($sformatf("Error at %0t: step %0d game_over_o %b, expected %b",
                       $time, step, got, exp));
  end
endtask

//////////////////////////////////////////////////////////////////////
// bounded waits
//////////////////////////////////////////////////////////////////////

task automatic wait_ack();
  int n;
  n = 0;
  @(negedge clk);
  while (!ack_o) begin
    if (n == ACK_LIMIT) begin
      fail_run("Timeout: the bus never acknowledged the cycle");
    end
    n++;
    @(negedge clk);
  end
endtask

// polls status until the game core is no longer busy
task automatic wait_settled();
  logic [WB_DAT_W-1:0] data;
  status_t             st;
  int                  n;
  n = 0;
  wb_read(REG_STATUS, data);
  st = status_t'(data[$bits(status_t)-1:0]);
  while (st.busy) begin
    if (n == SETTLE_LIMIT) begin
      fail_run("Timeout: the game core stayed busy");
    end
    n++;
    wb_read(REG_STATUS, data);
    st = status_t'(data[$bits(status_t)-1:0]);
  end
endtask

`endif

// File: sim/tetris_tb.sv
`timescale 1ns/10ps

module tetris_tb
  import tetris_grid_pkg::*;
  import tetris_game_pkg::*;
();

  localparam int ACK_LIMIT    = 500;  // cycles, covers a full line clear
  localparam int SETTLE_LIMIT = 50;   // status polls
  localparam int ALL_ROWS     = -1;

  typedef enum logic [1:0] {
    ACT_NONE,
    ACT_CMD,
    ACT_PRESET
  } act_t;

  typedef struct packed {
    act_t                 act;
    cmd_op_t              op;
    logic [7:0]           reps;
    logic [3:0]           preset;
    status_t              exp_status;
    logic [15:0]          exp_lines;
    logic                 all_rows;
    logic [4:0]           row_sel;
    row_t                 exp_row;
  } step_t;

  logic                clk;
  logic                rst;
  logic                cyc_i;
  logic                stb_i;
  logic                we_i;
  logic [WB_ADR_W-1:0] adr_i;
  logic [WB_DAT_W-1:0] dat_i;
  logic [WB_DAT_W-1:0] dat_o;
  logic                ack_o;
  logic                game_over_o;
  step_t               steps[$];

  tetris_top UUT (
    .clk(clk), .rst(rst),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .dat_i(dat_i),
    .dat_o(dat_o), .ack_o(ack_o), .game_over_o(game_over_o)
  );

  `include "tb_checks.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // wishbone master
  //////////////////////////////////////////////////////////////////////

  task automatic idle_gap();
    int unsigned gap;
    gap = $urandom % 4;
    repeat (gap) @(posedge clk);
  endtask

  task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WB_DAT_W-1:0] wdata,
                           output logic [WB_DAT_W-1:0] rdata);
    @(posedge clk);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= we;
    adr_i <= adr;
    dat_i <= wdata;
    wait_ack();  // stb stays up until ack
    rdata = dat_o;
    @(posedge clk);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    idle_gap();
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
    logic [WB_DAT_W-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // scenario table
  //////////////////////////////////////////////////////////////////////

  function automatic row_t make_row(logic [GRID_COLS-1:0] cols, cell_t colour);
    row_t r;
    r = '0;
    for (int c = 0; c < GRID_COLS; c++) begin
      if (cols[c]) begin
        r[c] = colour;
      end
    end
    return r;
  endfunction

  task automatic add_step(act_t act, cmd_op_t op, int reps, logic [3:0] preset,
                          game_state_t st, piece_kind_t kind, int rot, int col,
                          int lines, int row_sel, logic [GRID_COLS-1:0] cols,
                          cell_t colour);
    step_t s;
    s.act        = act;
    s.op         = op;
    s.reps       = 8'(reps);
    s.preset     = preset;
    s.exp_status = '{state: st, busy: 1'b0, game_over: (st == ST_OVER),
                     pos: '{kind: kind, rot: 2'(rot), row: 5'd0, col: 5'(col)}};
    s.exp_lines  = 16'(lines);
    s.all_rows   = (row_sel == ALL_ROWS);
    s.row_sel    = (row_sel == ALL_ROWS) ? 5'd0 : 5'(row_sel);
    s.exp_row    = make_row(cols, colour);
    steps.push_back(s);
  endtask

  // every check lands with the piece at the top row of the board
  task automatic load_steps();
    add_step(ACT_NONE, OP_START, 0, 4'h0, ST_IDLE, PK_O, 0, 0, 0, ALL_ROWS, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_START, 1, 4'h0, ST_PLAY, PK_O, 0, 3, 0, 0, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_LEFT, 1, 4'h0, ST_PLAY, PK_O, 0, 2, 0, 21, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_LEFT, 5, 4'h0, ST_PLAY, PK_O, 0, 0, 0, 21, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_RIGHT, 10, 4'h0, ST_PLAY, PK_O, 0, 8, 0, 21, 10'h000, 3'd0);
    // O lands in the bottom right corner, I comes next
    add_step(ACT_CMD, OP_DROP, 21, 4'h0, ST_PLAY, PK_I, 0, 3, 0, 21, 10'b11_0000_0000, 3'd1);
    add_step(ACT_NONE, OP_START, 0, 4'h0, ST_PLAY, PK_I, 0, 3, 0, 20, 10'b11_0000_0000, 3'd1);
    add_step(ACT_CMD, OP_ROT_CW, 1, 4'h0, ST_PLAY, PK_I, 1, 3, 0, 19, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_ROT_CW, 3, 4'h0, ST_PLAY, PK_I, 0, 3, 0, 19, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_ROT_CCW, 1, 4'h0, ST_PLAY, PK_I, 3, 3, 0, 19, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_ROT_CW, 1, 4'h0, ST_PLAY, PK_I, 0, 3, 0, 19, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_RIGHT, 6, 4'h0, ST_PLAY, PK_I, 0, 6, 0, 19, 10'h000, 3'd0);
    // flat I rests on the O
    add_step(ACT_CMD, OP_DROP, 19, 4'h0, ST_PLAY, PK_T, 0, 3, 0, 19, 10'b11_1100_0000, 3'd2);
    add_step(ACT_PRESET, OP_START, 0, 4'h8, ST_PLAY, PK_T, 0, 3, 0, 21, 10'b11_0000_0000, 3'd1);
    // stack forced O pieces at the spawn column until the spawn is blocked
    add_step(ACT_CMD, OP_DROP, 140, 4'h0, ST_OVER, PK_O, 0, 3, 0, 0, 10'b00_0001_1000, 3'd1);
    add_step(ACT_CMD, OP_START, 1, 4'h0, ST_PLAY, PK_O, 0, 3, 0, ALL_ROWS, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_LEFT, 4, 4'h0, ST_PLAY, PK_O, 0, 0, 0, 21, 10'h000, 3'd0);
    add_step(ACT_CMD, OP_DROP, 21, 4'h0, ST_PLAY, PK_O, 0, 3, 0, 21, 10'b00_0000_0011, 3'd1);
    add_step(ACT_CMD, OP_LEFT, 1, 4'h0, ST_PLAY, PK_O, 0, 2, 0, 21, 10'b00_0000_0011, 3'd1);
    add_step(ACT_CMD, OP_DROP, 21, 4'h0, ST_PLAY, PK_O, 0, 3, 0, 21, 10'b00_0000_1111, 3'd1);
    add_step(ACT_CMD, OP_RIGHT, 1, 4'h0, ST_PLAY, PK_O, 0, 4, 0, 21, 10'b00_0000_1111, 3'd1);
    add_step(ACT_CMD, OP_DROP, 21, 4'h0, ST_PLAY, PK_O, 0, 3, 0, 21, 10'b00_0011_1111, 3'd1);
    add_step(ACT_CMD, OP_RIGHT, 3, 4'h0, ST_PLAY, PK_O, 0, 6, 0, 20, 10'b00_0011_1111, 3'd1);
    add_step(ACT_CMD, OP_DROP, 21, 4'h0, ST_PLAY, PK_O, 0, 3, 0, 20, 10'b00_1111_1111, 3'd1);
    add_step(ACT_CMD, OP_RIGHT, 5, 4'h0, ST_PLAY, PK_O, 0, 8, 0, 20, 10'b00_1111_1111, 3'd1);
    add_step(ACT_CMD, OP_DROP, 21, 4'h0, ST_PLAY, PK_O, 0, 3, 2, ALL_ROWS, 10'h000, 3'd0);
  endtask

  task automatic run_step(int idx, step_t s);
    logic [WB_DAT_W-1:0] data;
    case (s.act)
      ACT_CMD:    repeat (s.reps) wb_write(REG_CTRL, WB_DAT_W'(s.op));
      ACT_PRESET: wb_write(REG_PRESET, WB_DAT_W'(s.preset));
      default:    ;
    endcase
    wait_settled();
    wb_read(REG_STATUS, data);
    check_status(idx, status_t'(data[$bits(status_t)-1:0]), s.exp_status);
    @(negedge clk);
    check_flag(idx, game_over_o, s.exp_status.game_over);
    wb_read(REG_LINES, data);
    check_count(idx, data[15:0], s.exp_lines);
    for (int r = 0; r < GRID_ROWS; r++) begin
      if (s.all_rows || r == s.row_sel) begin
        wb_read(WB_ADR_W'(REG_ROW_BASE + r), data);
        check_row(idx, r, row_t'(data[$bits(row_t)-1:0]), s.exp_row);
      end
    end
  endtask

  initial begin
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    adr_i <= '0;
    dat_i <= '0;
    rst   <= 1'b1;
    void'($urandom(32'h5add_3ad9));
    load_steps();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    foreach (steps[i]) begin
      run_step(i, steps[i]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+sim
hw/tetris_grid_pkg.sv
hw/tetris_game_pkg.sv
hw/piece_gen.sv
hw/piece_rom.sv
hw/fit_check.sv
hw/playfield.sv
hw/tetris_ctrl.sv
hw/tetris_wb_regs.sv
hw/tetris_top.sv
sim/tetris_tb.sv
